//--- bench/tb_clock_gen.sv
// ----------------------------------------------------------------------
// testbench clock and reset
// free-running clock, active-low reset held for a number of cycles
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // released on a rising edge once the count is reached
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

//--- bench/tb_lsu_top.sv
// ----------------------------------------------------------------------
// testbench of the load/store unit
// stimulus, reference model with shadow memory, compare process,
// watchdog and reporting
// ----------------------------------------------------------------------

`timescale 1ns/1ns

`include "lsu_params.svh"

module tb_lsu_top;
    import lsu_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int WORD_PAIRS = 16;
    localparam int NEG_PAIRS  = 8;
    localparam int MIX_OPS    = 200;
    // fill, word pairs, 24 sub-word ops, 15 misaligned ops, negative pairs, mix
    localparam int TOTAL_OPS  = `LSU_MEM_WORDS + 2*WORD_PAIRS + 24 + 15 + 2*NEG_PAIRS + MIX_OPS;
    // from the drive edge to the negedge after the output registers update
    localparam int LATENCY    = 4;

    typedef struct packed {
        logic        is_st;
        trans_id_t   id;
        xlen_t       result;
        logic        ex;
        cause_t      cause;
        xlen_t       tval;
        logic [31:0] due;
    } exp_t;

    logic      clk;
    logic      rst_n;
    logic      lsu_valid;
    lsu_op_e   op;
    xlen_t     operand_a;
    xlen_t     imm;
    xlen_t     operand_b;
    trans_id_t trans_id;
    logic      load_valid;
    trans_id_t load_trans_id;
    xlen_t     load_result;
    logic      load_ex_valid;
    cause_t    load_ex_cause;
    xlen_t     load_ex_tval;
    logic      store_valid;
    trans_id_t store_trans_id;
    logic      store_ex_valid;
    cause_t    store_ex_cause;
    xlen_t     store_ex_tval;

    xlen_t       shadow [`LSU_MEM_WORDS];
    exp_t        exp_q [$];
    logic [31:0] lcg_state = 32'd36;
    trans_id_t   next_id = '0;
    int unsigned cyc = 0;
    string       cur_test = "reset";
    int          test_errs = 0;
    int          total_errs = 0;
    int          checks = 0;
    int          tests = 0;
    lsu_op_e     mix_ops [8] = '{LSU_LB, LSU_LBU, LSU_LH, LSU_LHU,
                                 LSU_LW, LSU_SB, LSU_SH, LSU_SW};

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(16)) clock_gen_i (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    lsu_top dut_i (
        .clk_i (clk), .rst_ni (rst_n),
        .lsu_valid_i (lsu_valid), .op_i (op), .operand_a_i (operand_a),
        .imm_i (imm), .operand_b_i (operand_b), .trans_id_i (trans_id),
        .load_valid_o (load_valid), .load_trans_id_o (load_trans_id),
        .load_result_o (load_result), .load_ex_valid_o (load_ex_valid),
        .load_ex_cause_o (load_ex_cause), .load_ex_tval_o (load_ex_tval),
        .store_valid_o (store_valid), .store_trans_id_o (store_trans_id),
        .store_ex_valid_o (store_ex_valid), .store_ex_cause_o (store_ex_cause),
        .store_ex_tval_o (store_ex_tval)
    );

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // upper state bits come out in the low half
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    // ----------------------------------------------------------------------
    // reference model over the shadow memory in issue order
    // ----------------------------------------------------------------------
    function automatic exp_t predict_result(input lsu_op_e o, input xlen_t a, input xlen_t i,
                                            input xlen_t b, input trans_id_t id);
        exp_t     e;
        xlen_t    addr;
        mem_idx_t idx;
        int       off;
        int       size;
        logic     store;
        addr  = a + i;
        idx   = addr[9:2];
        off   = int'(addr[1:0]);
        store = (o == LSU_SB) || (o == LSU_SH) || (o == LSU_SW);
        case (o)
            LSU_SB, LSU_LB, LSU_LBU: size = 1;
            LSU_SH, LSU_LH, LSU_LHU: size = 2;
            default:                 size = 4;
        endcase
        e       = '0;
        e.is_st = store;
        e.id    = id;
        // natural alignment for halfwords and words
        e.ex    = (off % size) != 0;
        e.cause = store ? cause_t'(`LSU_CAUSE_ST_MISALIGNED) : cause_t'(`LSU_CAUSE_LD_MISALIGNED);
        e.tval  = addr;
        if (!e.ex) begin
            for (int k = 0; k < size; k++) begin
                if (store) begin
                    shadow[idx][8*(off+k) +: 8] = b[8*k +: 8];
                end else begin
                    e.result[8*k +: 8] = shadow[idx][8*(off+k) +: 8];
                end
            end
            // sign extension from the top loaded bit
            if ((o == LSU_LB || o == LSU_LH) && e.result[8*size-1]) begin
                e.result = e.result | (32'hffff_ffff << (8*size));
            end
        end
        return e;
    endfunction

    task automatic issue_op(input lsu_op_e o, input xlen_t a, input xlen_t i, input xlen_t b);
        exp_t e;
        @(posedge clk);
        lsu_valid <= 1'b1;
        op        <= o;
        operand_a <= a;
        imm       <= i;
        operand_b <= b;
        trans_id  <= next_id;
        e     = predict_result(o, a, i, b, next_id);
        e.due = cyc + LATENCY;
        exp_q.push_back(e);
        next_id = next_id + 3'd1;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    // idle the input, drain the pending results, report the test
    task automatic finish_test();
        @(posedge clk);
        lsu_valid <= 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
        $display("test %-10s %0d errors", cur_test, test_errs);
        total_errs += test_errs;
        tests++;
    endtask

    task automatic check_field(input string field, input logic [31:0] expv,
                               input logic [31:0] actv);
        if (expv !== actv) begin
            $display("MISMATCH %s %s: expected %h, actual %h", cur_test, field, expv, actv);
            test_errs++;
        end
    endtask

    // ----------------------------------------------------------------------
    // compare process
    // ----------------------------------------------------------------------
    always @(negedge clk) begin : compare
        exp_t e;
        if (rst_n) begin
            if (exp_q.size() > 0 && exp_q[0].due < cyc) begin
                $display("ERROR %s: no result for id %0d in cycle %0d",
                         cur_test, exp_q[0].id, exp_q[0].due);
                test_errs++;
                e = exp_q.pop_front();
            end
            if (load_valid || store_valid) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR %s: output valid in cycle %0d with nothing pending",
                             cur_test, cyc);
                    test_errs++;
                end else begin
                    e = exp_q.pop_front();
                    checks++;
                    check_field("cycle", e.due, cyc);
                    check_field("store channel", 32'(e.is_st), 32'(store_valid));
                    check_field("load channel", 32'(!e.is_st), 32'(load_valid));
                    if (e.is_st) begin
                        check_field("store id", 32'(e.id), 32'(store_trans_id));
                        check_field("store ex_valid", 32'(e.ex), 32'(store_ex_valid));
                        if (e.ex) begin
                            check_field("store cause", 32'(e.cause), 32'(store_ex_cause));
                            check_field("store tval", e.tval, store_ex_tval);
                        end
                    end else begin
                        check_field("load id", 32'(e.id), 32'(load_trans_id));
                        check_field("load result", e.result, load_result);
                        check_field("load ex_valid", 32'(e.ex), 32'(load_ex_valid));
                        if (e.ex) begin
                            check_field("load cause", 32'(e.cause), 32'(load_ex_cause));
                            check_field("load tval", e.tval, load_ex_tval);
                        end
                    end
                end
            end
            if ((load_ex_valid && !load_valid) || (store_ex_valid && !store_valid)) begin
                $display("ERROR %s: exception raised without a valid output", cur_test);
                test_errs++;
            end
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    initial begin : stimulus
        xlen_t      a;
        xlen_t      i;
        xlen_t      d;
        logic [7:0] w8;
        lsu_valid = 1'b0;
        op        = LSU_LW;
        operand_a = '0;
        imm       = '0;
        operand_b = '0;
        trans_id  = '0;
        @(posedge rst_n);

        start_test("idle");
        repeat (10) begin
            @(negedge clk);
            if (load_valid || load_ex_valid || store_valid || store_ex_valid) begin
                $display("ERROR idle: an output valid is high before any operation");
                test_errs++;
            end
        end
        finish_test();

        // every word gets a pattern from its own index
        start_test("fill");
        for (int w = 0; w < `LSU_MEM_WORDS; w++) begin
            w8 = 8'(w);
            issue_op(LSU_SW, xlen_t'(w) << 2, '0, {w8, ~w8, w8 ^ 8'h5a, w8 + 8'h33});
        end
        finish_test();

        start_test("word_rw");
        for (int n = 0; n < WORD_PAIRS; n++) begin
            a = lcg_next() & 32'hffff_fffc;
            d = lcg_next();
            issue_op(LSU_SW, a, '0, d);
            issue_op(LSU_LW, a, '0, '0);
        end
        finish_test();

        start_test("sub_word");
        for (int o = 0; o < 4; o++) begin
            d    = lcg_next();
            d[7] = (o % 2 == 0);
            issue_op(LSU_SB, 32'h100, xlen_t'(o), d);
            issue_op(LSU_LB, 32'h100, xlen_t'(o), '0);
            issue_op(LSU_LBU, 32'h100, xlen_t'(o), '0);
            issue_op(LSU_LW, 32'h100, '0, '0);
        end
        for (int o = 0; o < 4; o += 2) begin
            d     = lcg_next();
            d[15] = (o == 0);
            issue_op(LSU_SH, 32'h100, xlen_t'(o), d);
            issue_op(LSU_LH, 32'h100, xlen_t'(o), '0);
            issue_op(LSU_LHU, 32'h100, xlen_t'(o), '0);
            issue_op(LSU_LW, 32'h100, '0, '0);
        end
        finish_test();

        start_test("misaligned");
        for (int o = 1; o < 4; o++) begin
            issue_op(LSU_SW, 32'h180, xlen_t'(o), lcg_next());
            issue_op(LSU_LW, 32'h180, xlen_t'(o), '0);
            issue_op(LSU_LW, 32'h180, '0, '0);
        end
        for (int o = 1; o < 4; o += 2) begin
            issue_op(LSU_SH, 32'h180, xlen_t'(o), lcg_next());
            issue_op(LSU_LH, 32'h180, xlen_t'(o), '0);
            issue_op(LSU_LW, 32'h180, '0, '0);
        end
        finish_test();

        start_test("neg_imm");
        for (int n = 0; n < NEG_PAIRS; n++) begin
            a = 32'h300 + (lcg_next() & 32'h0fc);
            i = -(lcg_next() & 32'h1fc);
            issue_op(LSU_SW, a, i, lcg_next());
            issue_op(LSU_LW, a + i, '0, '0);
        end
        finish_test();

        start_test("random_mix");
        for (int n = 0; n < MIX_OPS; n++) begin
            d = lcg_next();
            i = lcg_next();
            issue_op(mix_ops[d[2:0]], lcg_next(), {{20{i[11]}}, i[11:0]}, lcg_next());
        end
        finish_test();

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, total_errs);
        if (total_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin : watchdog
        #((TOTAL_OPS + 200) * CLK_PERIOD);
        $display("ERROR watchdog: run did not finish within %0d cycles", TOTAL_OPS + 200);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+source
source/lsu_pkg.sv
source/lsu_stage_if.sv
source/lsu_decode.sv
source/lsu_execute.sv
source/lsu_result.sv
source/lsu_top.sv
bench/tb_clock_gen.sv
bench/tb_lsu_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_lsu_top -o tb_lsu_top

./obj_dir/tb_lsu_top | tee sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0

//--- source/lsu_decode.sv
// ------------------------------------------------------------------
// decode stage of the load/store unit
// address generation, byte enables, store lane shift,
// misalignment check and the request register
// ------------------------------------------------------------------

`timescale 1ns/1ns

module lsu_decode (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               valid_i,
    input  lsu_pkg::lsu_op_e   op_i,
    input  lsu_pkg::xlen_t     operand_a_i,
    input  lsu_pkg::xlen_t     imm_i,
    input  lsu_pkg::xlen_t     operand_b_i,
    input  lsu_pkg::trans_id_t trans_id_i,
    lsu_req_if.decode_mp       req
);
    import lsu_pkg::*;

    xlen_t     vaddr;
    byte_off_t offset;
    be_t       be;
    xlen_t     wdata;
    logic      misaligned;

    // ------------------------------------------------------------------
    // address generation
    // ------------------------------------------------------------------
    // immediate arrives already sign-extended, no translation
    assign vaddr  = operand_a_i + imm_i;
    assign offset = vaddr[1:0];

    // store data moves up into the addressed byte lanes
    assign wdata = operand_b_i << {offset, 3'b000};

    // ------------------------------------------------------------------
    // byte enable and misalignment
    // ------------------------------------------------------------------
    always_comb begin
        be         = '1;
        misaligned = 1'b0;
        case (op_i)
            LSU_LB, LSU_LBU, LSU_SB: begin
                be = be_t'(4'b0001 << offset);
            end
            LSU_LH, LSU_LHU, LSU_SH: begin
                be         = be_t'(4'b0011 << offset);
                misaligned = offset[0];
            end
            default: begin
                // full word
                be         = '1;
                misaligned = (offset != 2'b00);
            end
        endcase
    end

    // ------------------------------------------------------------------
    // request register
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= valid_i;
        end
    end

    // payload, qualified by valid downstream
    always_ff @(posedge clk_i) begin
        req.op         <= op_i;
        req.vaddr      <= vaddr;
        req.wdata      <= wdata;
        req.be         <= be;
        req.trans_id   <= trans_id_i;
        req.misaligned <= misaligned;
    end

    // an accepted operation always touches at least one byte lane
    a_be_nonzero : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        valid_i |=> (req.be != '0)
    );

endmodule

//--- source/lsu_execute.sv
// ------------------------------------------------------------------
// execute stage of the load/store unit
// on-chip data memory with byte-enabled writes, registered reads
// ------------------------------------------------------------------

`timescale 1ns/1ns

`include "lsu_params.svh"

module lsu_execute (
    input  logic          clk_i,
    input  logic          rst_ni,
    lsu_req_if.execute_mp req,
    lsu_rsp_if.execute_mp rsp
);
    import lsu_pkg::*;

    xlen_t    mem_q [`LSU_MEM_WORDS];
    mem_idx_t idx;
    logic     write_en;
    logic     read_en;

    // word index, upper address bits are ignored
    assign idx = req.vaddr[`LSU_MEM_IDX_BITS+1:2];

    // misaligned stores never reach the memory
    assign write_en = req.valid && is_store(req.op) && !req.misaligned;
    assign read_en  = req.valid && !is_store(req.op);

    // ------------------------------------------------------------------
    // data memory
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        for (int unsigned b = 0; b < `LSU_XLEN/8; b++) begin
            if (write_en && req.be[b]) begin
                mem_q[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (read_en) begin
            rsp.rdata <= mem_q[idx];
        end
    end

    // ------------------------------------------------------------------
    // response register
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= req.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        rsp.op         <= req.op;
        rsp.vaddr      <= req.vaddr;
        rsp.trans_id   <= req.trans_id;
        rsp.misaligned <= req.misaligned;
    end

    // a misaligned store leaves its addressed word as it was
    a_misaligned_no_write : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (req.valid && req.misaligned && is_store(req.op))
            |=> (mem_q[$past(idx)] === $past(mem_q[idx]))
    );

endmodule

//--- source/lsu_params.svh
// ------------------------------------------------------------------
// load/store unit configuration
// data width, memory depth, id width and exception cause codes
// ------------------------------------------------------------------

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// data and address width
`define LSU_XLEN 32

// on-chip data memory, in 32-bit words
`define LSU_MEM_WORDS 256
`define LSU_MEM_IDX_BITS 8

// scoreboard transaction id
`define LSU_TRANS_ID_BITS 3

// RISC-V exception causes
`define LSU_CAUSE_LD_MISALIGNED 4
`define LSU_CAUSE_ST_MISALIGNED 6

`endif

//--- source/lsu_pkg.sv
// ------------------------------------------------------------------
// shared types of the load/store unit
// word, byte enable, id, index and cause types, the operation enum
// ------------------------------------------------------------------

`include "lsu_params.svh"

package lsu_pkg;

    // ------------------------------------------------------------------
    // vector types
    // ------------------------------------------------------------------
    typedef logic [`LSU_XLEN-1:0]          xlen_t;
    typedef logic [`LSU_XLEN/8-1:0]        be_t;
    typedef logic [`LSU_TRANS_ID_BITS-1:0] trans_id_t;
    typedef logic [`LSU_MEM_IDX_BITS-1:0]  mem_idx_t;
    typedef logic [1:0]                    byte_off_t;
    typedef logic [3:0]                    cause_t;

    // ------------------------------------------------------------------
    // operations
    // ------------------------------------------------------------------
    // loads in the lower half, stores from 8 upwards
    typedef enum logic [3:0] {
        LSU_LB  = 4'h0,
        LSU_LBU = 4'h1,
        LSU_LH  = 4'h2,
        LSU_LHU = 4'h3,
        LSU_LW  = 4'h4,
        LSU_SB  = 4'h8,
        LSU_SH  = 4'h9,
        LSU_SW  = 4'ha
    } lsu_op_e;

    // store channel or load channel
    function automatic logic is_store(lsu_op_e op);
        return op inside {LSU_SB, LSU_SH, LSU_SW};
    endfunction

endpackage

//--- source/lsu_result.sv
// ------------------------------------------------------------------
// result stage of the load/store unit
// load alignment and extension, misaligned exceptions,
// output registers of the load and store channels
// ------------------------------------------------------------------

`timescale 1ns/1ns

`include "lsu_params.svh"

module lsu_result (
    input  logic               clk_i,
    input  logic               rst_ni,
    lsu_rsp_if.result_mp       rsp,
    // load channel
    output logic               load_valid_o,
    output lsu_pkg::trans_id_t load_trans_id_o,
    output lsu_pkg::xlen_t     load_result_o,
    output logic               load_ex_valid_o,
    output lsu_pkg::cause_t    load_ex_cause_o,
    output lsu_pkg::xlen_t     load_ex_tval_o,
    // store channel
    output logic               store_valid_o,
    output lsu_pkg::trans_id_t store_trans_id_o,
    output logic               store_ex_valid_o,
    output lsu_pkg::cause_t    store_ex_cause_o,
    output lsu_pkg::xlen_t     store_ex_tval_o
);
    import lsu_pkg::*;

    logic  is_st;
    xlen_t lane_data;
    xlen_t load_data;

    assign is_st = is_store(rsp.op);

    // ------------------------------------------------------------------
    // load alignment and extension
    // ------------------------------------------------------------------
    // addressed byte or halfword moves down to lane 0
    assign lane_data = rsp.rdata >> {rsp.vaddr[1:0], 3'b000};

    always_comb begin
        case (rsp.op)
            LSU_LB:  load_data = {{(`LSU_XLEN-8){lane_data[7]}}, lane_data[7:0]};
            LSU_LBU: load_data = {{(`LSU_XLEN-8){1'b0}}, lane_data[7:0]};
            LSU_LH:  load_data = {{(`LSU_XLEN-16){lane_data[15]}}, lane_data[15:0]};
            LSU_LHU: load_data = {{(`LSU_XLEN-16){1'b0}}, lane_data[15:0]};
            default: load_data = rsp.rdata;
        endcase
        // faulting loads return zero
        if (rsp.misaligned) begin
            load_data = '0;
        end
    end

    // ------------------------------------------------------------------
    // output registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            load_valid_o     <= 1'b0;
            load_ex_valid_o  <= 1'b0;
            store_valid_o    <= 1'b0;
            store_ex_valid_o <= 1'b0;
        end else begin
            load_valid_o     <= rsp.valid && !is_st;
            load_ex_valid_o  <= rsp.valid && !is_st && rsp.misaligned;
            store_valid_o    <= rsp.valid && is_st;
            store_ex_valid_o <= rsp.valid && is_st && rsp.misaligned;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp.valid && !is_st) begin
            load_trans_id_o <= rsp.trans_id;
            load_result_o   <= load_data;
            load_ex_cause_o <= rsp.misaligned ? cause_t'(`LSU_CAUSE_LD_MISALIGNED) : '0;
            load_ex_tval_o  <= rsp.misaligned ? rsp.vaddr : '0;
        end
        if (rsp.valid && is_st) begin
            store_trans_id_o <= rsp.trans_id;
            store_ex_cause_o <= rsp.misaligned ? cause_t'(`LSU_CAUSE_ST_MISALIGNED) : '0;
            store_ex_tval_o  <= rsp.misaligned ? rsp.vaddr : '0;
        end
    end

    a_one_channel : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(load_valid_o && store_valid_o)
    );

endmodule

//--- source/lsu_stage_if.sv
// ------------------------------------------------------------------
// stage interfaces of the load/store unit
// lsu_req_if from decode to execute
// lsu_rsp_if from execute to result
// ------------------------------------------------------------------

`timescale 1ns/1ns

// registered request with address, lane-aligned store data and byte enable
interface lsu_req_if;
    import lsu_pkg::*;

    logic      valid;
    lsu_op_e   op;
    xlen_t     vaddr;
    xlen_t     wdata;
    be_t       be;
    trans_id_t trans_id;
    logic      misaligned;

    modport decode_mp (
        output valid, op, vaddr, wdata, be, trans_id, misaligned
    );

    modport execute_mp (
        input valid, op, vaddr, wdata, be, trans_id, misaligned
    );
endinterface

// registered memory response, raw word before lane selection
interface lsu_rsp_if;
    import lsu_pkg::*;

    logic      valid;
    lsu_op_e   op;
    xlen_t     vaddr;
    xlen_t     rdata;
    trans_id_t trans_id;
    logic      misaligned;

    modport execute_mp (
        output valid, op, vaddr, rdata, trans_id, misaligned
    );

    modport result_mp (
        input valid, op, vaddr, rdata, trans_id, misaligned
    );
endinterface

//--- source/lsu_top.sv
// ------------------------------------------------------------------
// load/store unit top level
// decode, execute and result stages joined by two stage interfaces
// ------------------------------------------------------------------

`timescale 1ns/1ns

module lsu_top (
    input  logic               clk_i,
    input  logic               rst_ni,
    // operation in
    input  logic               lsu_valid_i,
    input  lsu_pkg::lsu_op_e   op_i,
    input  lsu_pkg::xlen_t     operand_a_i,
    input  lsu_pkg::xlen_t     imm_i,
    input  lsu_pkg::xlen_t     operand_b_i,
    input  lsu_pkg::trans_id_t trans_id_i,
    // load write-back
    output logic               load_valid_o,
    output lsu_pkg::trans_id_t load_trans_id_o,
    output lsu_pkg::xlen_t     load_result_o,
    output logic               load_ex_valid_o,
    output lsu_pkg::cause_t    load_ex_cause_o,
    output lsu_pkg::xlen_t     load_ex_tval_o,
    // store write-back
    output logic               store_valid_o,
    output lsu_pkg::trans_id_t store_trans_id_o,
    output logic               store_ex_valid_o,
    output lsu_pkg::cause_t    store_ex_cause_o,
    output lsu_pkg::xlen_t     store_ex_tval_o
);

    lsu_req_if req_if ();
    lsu_rsp_if rsp_if ();

    // ------------------------------------------------------------------
    // stages
    // ------------------------------------------------------------------
    lsu_decode decode_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .valid_i     (lsu_valid_i),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .imm_i       (imm_i),
        .operand_b_i (operand_b_i),
        .trans_id_i  (trans_id_i),
        .req         (req_if.decode_mp)
    );

    lsu_execute execute_i (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .req    (req_if.execute_mp),
        .rsp    (rsp_if.execute_mp)
    );

    lsu_result result_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .rsp              (rsp_if.result_mp),
        .load_valid_o     (load_valid_o),
        .load_trans_id_o  (load_trans_id_o),
        .load_result_o    (load_result_o),
        .load_ex_valid_o  (load_ex_valid_o),
        .load_ex_cause_o  (load_ex_cause_o),
        .load_ex_tval_o   (load_ex_tval_o),
        .store_valid_o    (store_valid_o),
        .store_trans_id_o (store_trans_id_o),
        .store_ex_valid_o (store_ex_valid_o),
        .store_ex_cause_o (store_ex_cause_o),
        .store_ex_tval_o  (store_ex_tval_o)
    );

endmodule
